/* source/coreHarnessPkg.sv */
package coreHarnessPkg;

  // ------------------------------------------------------------
  // Downstream word formats
  // ------------------------------------------------------------

  // Top two bits of a host word; 01 only occurs inside a chip half
  typedef enum logic [1:0] {
    toBd      = 2'b00,  // Message to the chip
    regWrite  = 2'b10,  // Register write
    chanWrite = 2'b11   // Channel write
  } wordTag_e;

  typedef struct packed {
    wordTag_e    tag;
    logic        spare0;
    logic [4:0]  id;      // Register index
    logic [7:0]  spare1;
    logic [15:0] data;
  } regWord_t;

  // Same layout, but id names a channel
  typedef struct packed {
    wordTag_e    tag;
    logic        spare0;
    logic [4:0]  id;
    logic [7:0]  spare1;
    logic [15:0] data;
  } chanWord_t;

  typedef struct packed {
    wordTag_e    tag;
    logic [5:0]  code;     // Chip message code
    logic [3:0]  spare;
    logic [19:0] payload;
  } toBdWord_t;

  // Simulated chip output, sent as low half then high half
  typedef struct packed {
    logic [7:0]  marker;   // All ones
    logic [23:0] payload;  // High half uses bits 9:0 only
  } fromBdHalf_t;

  // One host word, decoded by whichever view the tag selects
  typedef union packed {
    regWord_t    regW;
    chanWord_t   chanW;
    toBdWord_t   toBdW;
    fromBdHalf_t fromBd;
  } downWord_u;

  localparam logic [7:0] bdMarker = 8'hFF;

  typedef logic [33:0] bdWord_t;  // Assembled chip word

  // ------------------------------------------------------------
  // Decoder to encoder events
  // ------------------------------------------------------------
  typedef struct packed {
    logic        echoValid;      // Echo the original word
    logic        bdValid;        // Frame a chip word
    logic        readbackValid;  // Channel readback
    logic [31:0] word;           // Original host word
    bdWord_t     bdWord;
    logic [4:0]  readbackId;
  } upEvent_t;

  // Upstream tags in bits 31:30
  localparam logic [1:0] upEcho     = 2'b00;
  localparam logic [1:0] upBdHigh   = 2'b01;  // Chip word bits 33:24 in 9:0
  localparam logic [1:0] upBdLow    = 2'b10;  // Chip word bits 23:0 in 23:0
  localparam logic [1:0] upReadback = 2'b11;  // Id in 20:16, value in 15:0

  // Register indices
  localparam logic [4:0] ledReg      = 5'd0;
  localparam logic [4:0] readbackReg = 5'd2;
  localparam logic [4:0] nopReg      = 5'd31;  // Filler, writes ignored

endpackage

/* source/downstreamDecoder.sv */
`timescale 1ns/1ps

module downstreamDecoder
  import coreHarnessPkg::*;
(
  input  logic        okClk,
  input  logic        arstN,
  input  logic        pipeInWrite,  // One word per cycle at most
  input  downWord_u   pipeInData,
  output logic        regWrite,     // Strobes, one cycle wide
  output logic        chanWrite,
  output logic [4:0]  writeId,
  output logic [15:0] writeData,
  output upEvent_t    upEvent
);

  logic        isBdHalf;
  logic        isHighHalf;
  logic        isToBd;
  logic        isReg;
  logic        isChan;
  logic        echoQ;
  logic        bdQ;
  logic        readbackQ;
  logic        lowValid;     // Low chip half waiting for its high half
  logic [23:0] lowHalf;
  logic [31:0] wordQ;
  bdWord_t     bdWordQ;
  logic [4:0]  readbackIdQ;

  // ------------------------------------------------------------
  // Word classification
  // ------------------------------------------------------------
  // Chip halves are checked first since their marker overlaps tag 11
  assign isBdHalf   = pipeInData.fromBd.marker == bdMarker;
  // High half carries only 10 bits, so bits 23:10 are zero
  assign isHighHalf = isBdHalf && (pipeInData.fromBd.payload[23:10] == '0);
  assign isToBd = !isBdHalf && (pipeInData.toBdW.tag == coreHarnessPkg::toBd);
  assign isReg  = !isBdHalf && (pipeInData.regW.tag == coreHarnessPkg::regWrite)
                  && (pipeInData.regW.id != nopReg);  // Drop filler
  assign isChan = !isBdHalf && (pipeInData.chanW.tag == coreHarnessPkg::chanWrite);

  // Strobes and pending-half flag
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      regWrite  <= 1'b0;
      chanWrite <= 1'b0;
      echoQ     <= 1'b0;
      bdQ       <= 1'b0;
      readbackQ <= 1'b0;
      lowValid  <= 1'b0;
    end else begin
      regWrite  <= pipeInWrite && isReg;
      chanWrite <= pipeInWrite && isChan;
      echoQ     <= pipeInWrite && isToBd;
      readbackQ <= pipeInWrite && isReg && (pipeInData.regW.id == readbackReg);
      bdQ       <= pipeInWrite && isHighHalf && lowValid;  // Lone high half discarded
      if (pipeInWrite && isBdHalf) begin
        lowValid <= !isHighHalf;  // High half consumes and low half rearms
      end
    end
  end

  // Payload capture
  always_ff @(posedge okClk) begin
    if (pipeInWrite) begin
      wordQ       <= pipeInData;
      writeId     <= pipeInData.regW.id;    // Channel words share this layout
      writeData   <= pipeInData.regW.data;
      readbackIdQ <= pipeInData.regW.data[4:0];  // Channel named in low bits
      if (isBdHalf && !isHighHalf) begin
        lowHalf <= pipeInData.fromBd.payload;    // Newer low half wins
      end
      if (isHighHalf) begin
        bdWordQ <= {pipeInData.fromBd.payload[9:0], lowHalf};
      end
    end
  end

  always_comb begin
    upEvent.echoValid     = echoQ;
    upEvent.bdValid       = bdQ;
    upEvent.readbackValid = readbackQ;
    upEvent.word          = wordQ;
    upEvent.bdWord        = bdWordQ;
    upEvent.readbackId    = readbackIdQ;
  end

endmodule

/* source/configRegisters.sv */
`timescale 1ns/1ps

module configRegisters
  import coreHarnessPkg::*;
(
  input  logic        okClk,
  input  logic        arstN,
  input  logic        regWrite,
  input  logic        chanWrite,
  input  logic [4:0]  writeId,
  input  logic [15:0] writeData,
  input  logic [4:0]  readbackId,
  output logic [3:0]  led,
  output logic [15:0] readbackValue  // Combinational lookup
);

  logic [31:0][15:0] chanVal;  // Channel storage

  // ------------------------------------------------------------
  // Register file
  // ------------------------------------------------------------
  // Register 2 and the rest only raise events in the decoder
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      led     <= '0;
      chanVal <= '0;
    end else begin
      if (regWrite && (writeId == ledReg)) begin
        led <= writeData[3:0];  // LEDs take low nibble
      end
      if (chanWrite) begin
        chanVal[writeId] <= writeData;
      end
    end
  end

  // Readback from current storage
  assign readbackValue = chanVal[readbackId];

endmodule

/* source/upstreamEncoder.sv */
`timescale 1ns/1ps

module upstreamEncoder
  import coreHarnessPkg::*;
(
  input  logic        okClk,
  input  logic        arstN,
  input  upEvent_t    upEvent,
  input  logic [15:0] readbackValue,
  output logic [4:0]  readbackId,  // Lookup address for the registers
  output logic        push,
  output logic [31:0] pushData
);

  logic        lowPending;  // Low frame word due next cycle
  logic [31:0] lowWord;
  logic [31:0] highWord;
  logic [31:0] readbackWord;
  logic [31:0] echoWord;
  logic [31:0] eventWord;
  logic        eventValid;

  assign readbackId = upEvent.readbackId;

  // ------------------------------------------------------------
  // Upstream word formats
  // ------------------------------------------------------------
  assign highWord     = {upBdHigh, 20'b0, upEvent.bdWord[33:24]};
  assign readbackWord = {upReadback, 9'b0, upEvent.readbackId, readbackValue};
  assign echoWord     = {upEcho, upEvent.word[29:0]};  // Tag already 00

  assign eventValid = upEvent.echoValid | upEvent.bdValid | upEvent.readbackValid;

  // At most one event kind per host word
  always_comb begin
    if (upEvent.bdValid) begin
      eventWord = highWord;       // High word goes first
    end else if (upEvent.readbackValid) begin
      eventWord = readbackWord;
    end else begin
      eventWord = echoWord;
    end
  end

  // Push strobe and frame sequencing
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      push       <= 1'b0;
      lowPending <= 1'b0;
    end else begin
      push       <= lowPending | eventValid;
      lowPending <= upEvent.bdValid;  // Host idles after a high half
    end
  end

  always_ff @(posedge okClk) begin
    lowWord <= {upBdLow, 6'b0, upEvent.bdWord[23:0]};
    // Held low word ahead of any new event
    if (lowPending) begin
      pushData <= lowWord;
    end else begin
      pushData <= eventWord;
    end
  end

endmodule

/* source/upstreamFifo.sv */
`timescale 1ns/1ps

module upstreamFifo #(
  parameter int FifoDepth = 16
) (
  input  logic        okClk,
  input  logic        arstN,
  input  logic        push,
  input  logic [31:0] pushData,
  input  logic        pop,
  output logic [31:0] headData,  // Fall-through head word
  output logic        empty,
  output logic        overflow   // Sticky until reset
);

  localparam int PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CntW = $clog2(FifoDepth + 1);

  logic [31:0]     mem [FifoDepth];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] count;
  logic            full;
  logic            doPush;
  logic            doPop;

  assign full   = count == CntW'(FifoDepth);
  assign empty  = count == '0;
  assign doPush = push && !full;   // Dropped when full
  assign doPop  = pop && !empty;   // Pop on empty ignored

  // ------------------------------------------------------------
  // Pointers, count and overflow
  // ------------------------------------------------------------
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == PtrW'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;  // Any depth
      end
      if (doPop) begin
        rdPtr <= (rdPtr == PtrW'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      count <= count + CntW'(doPush) - CntW'(doPop);
      if (push && full) begin
        overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge okClk) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

  assign headData = mem[rdPtr];

endmodule

/* source/coreHarness.sv */
`timescale 1ns/1ps

module coreHarness
  import coreHarnessPkg::*;
#(
  parameter int FifoDepth = 16  // Upstream FIFO words
) (
  input  logic        okClk,
  input  logic        arstN,
  input  logic        pipeInWrite,
  input  logic [31:0] pipeInData,
  input  logic        pipeOutRead,
  output logic [31:0] pipeOutData,
  output logic        pipeOutEmpty,
  output logic        pipeOutOverflow,
  output logic [3:0]  led
);

  logic        regWrite;
  logic        chanWrite;
  logic [4:0]  writeId;
  logic [15:0] writeData;
  upEvent_t    upEvent;
  logic [4:0]  readbackId;
  logic [15:0] readbackValue;
  logic        push;
  logic [31:0] pushData;

  // ------------------------------------------------------------
  // Downstream path
  // ------------------------------------------------------------
  downstreamDecoder decoder (
    .okClk       (okClk),
    .arstN       (arstN),
    .pipeInWrite (pipeInWrite),
    .pipeInData  (pipeInData),
    .regWrite    (regWrite),
    .chanWrite   (chanWrite),
    .writeId     (writeId),
    .writeData   (writeData),
    .upEvent     (upEvent)
  );

  configRegisters registers (
    .okClk         (okClk),
    .arstN         (arstN),
    .regWrite      (regWrite),
    .chanWrite     (chanWrite),
    .writeId       (writeId),
    .writeData     (writeData),
    .readbackId    (readbackId),
    .led           (led),
    .readbackValue (readbackValue)
  );

  // Upstream path
  upstreamEncoder encoder (
    .okClk         (okClk),
    .arstN         (arstN),
    .upEvent       (upEvent),
    .readbackValue (readbackValue),
    .readbackId    (readbackId),
    .push          (push),
    .pushData      (pushData)
  );

  upstreamFifo #(
    .FifoDepth (FifoDepth)
  ) fifo (
    .okClk    (okClk),
    .arstN    (arstN),
    .push     (push),
    .pushData (pushData),
    .pop      (pipeOutRead),
    .headData (pipeOutData),
    .empty    (pipeOutEmpty),
    .overflow (pipeOutOverflow)
  );

endmodule

/* tb/coreHarness_tb.sv */
`timescale 1ns/1ps

module coreHarness_tb
  import coreHarnessPkg::*;
();

  localparam int FifoDepth = 16;
  localparam int WaitLimit = 40;  // Cycles allowed per wait

  logic        okClk;
  logic        arstN;
  logic        pipeInWrite;
  logic [31:0] pipeInData;
  logic        pipeOutRead;
  logic [31:0] pipeOutData;
  logic        pipeOutEmpty;
  logic        pipeOutOverflow;
  logic [3:0]  led;

  logic [31:0] expQ [$];        // Expected upstream words, in order
  logic [15:0] chanModel [32];
  logic [3:0]  ledModel;
  int          seed;
  int          checks;
  int          errors;
  int          timeouts;

  coreHarness #(.FifoDepth(FifoDepth)) DUT (
    .okClk(okClk), .arstN(arstN), .pipeInWrite(pipeInWrite), .pipeInData(pipeInData),
    .pipeOutRead(pipeOutRead), .pipeOutData(pipeOutData), .pipeOutEmpty(pipeOutEmpty),
    .pipeOutOverflow(pipeOutOverflow), .led(led)
  );

  initial begin
    okClk = 1'b0;
    forever #50 okClk = ~okClk;  // 100 ns period
  end

  // ------------------------------------------------------------
  // Host word formats
  // ------------------------------------------------------------
  function automatic logic [31:0] toBdWord(logic [5:0] code, logic [19:0] payload);
    return {2'b00, code, 4'b0, payload};
  endfunction

  function automatic logic [31:0] regWord(logic [4:0] id, logic [15:0] data);
    return {2'b10, 1'b0, id, 8'b0, data};
  endfunction

  function automatic logic [31:0] chanWord(logic [4:0] id, logic [15:0] data);
    return {2'b11, 1'b0, id, 8'b0, data};
  endfunction

  task automatic checkValue(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (act == exp) else begin
      errors++;
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic sendWord(logic [31:0] word);
    @(posedge okClk);
    pipeInWrite <= 1'b1;
    pipeInData  <= word;
    @(posedge okClk);
    pipeInWrite <= 1'b0;  // Idle cycle after every word
  endtask

  // Nothing more may arrive once the pipeline has settled
  task automatic expectEmpty();
    repeat (4) @(negedge okClk);
    checkValue("pipeOutEmpty", 32'd1, 32'(pipeOutEmpty));
  endtask

  // Pop every expected word and check the head before each pop
  task automatic drainAll();
    int          waited;
    logic [31:0] exp;
    while (expQ.size() > 0) begin
      waited = 0;
      @(negedge okClk);
      while (pipeOutEmpty && waited < WaitLimit) begin
        @(negedge okClk);
        waited++;
      end
      if (pipeOutEmpty) begin
        timeouts++;
        $display("Timeout at %0t ns: %0d upstream words never arrived", $time, expQ.size());
        expQ.delete();
      end else begin
        exp = expQ.pop_front();
        checkValue("pipeOutData", exp, pipeOutData);
        @(posedge okClk);
        pipeOutRead <= 1'b1;
        @(posedge okClk);
        pipeOutRead <= 1'b0;
      end
    end
  endtask

  task automatic waitLed(logic [3:0] exp);
    int waited;
    waited = 0;
    @(negedge okClk);
    while (led != exp && waited < WaitLimit) begin
      @(negedge okClk);
      waited++;
    end
    checkValue("led", 32'(exp), 32'(led));
  endtask

  task automatic waitOverflow();
    int waited;
    waited = 0;
    @(negedge okClk);
    while (!pipeOutOverflow && waited < WaitLimit) begin
      @(negedge okClk);
      waited++;
    end
    checkValue("pipeOutOverflow", 32'd1, 32'(pipeOutOverflow));
  endtask

  task automatic checkReset();
    @(negedge okClk);
    checkValue("pipeOutEmpty", 32'd1, 32'(pipeOutEmpty));
    checkValue("pipeOutOverflow", 32'd0, 32'(pipeOutOverflow));
    checkValue("led", 32'd0, 32'(led));
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] w;
    logic [23:0] lowBits;
    logic [9:0]  highBits;
    logic [15:0] data;
    seed     = 46747;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    ledModel = '0;
    foreach (chanModel[i]) chanModel[i] = '0;
    arstN       <= 1'b0;
    pipeInWrite <= 1'b0;
    pipeInData  <= '0;
    pipeOutRead <= 1'b0;
    repeat (2) @(posedge okClk);
    arstN <= 1'b1;
    checkReset();

    repeat (8) begin  // Echo, unchanged and in order
      r = $random(seed);
      w = toBdWord(r[25:20], r[19:0]);
      sendWord(w);
      expQ.push_back(w);
    end
    drainAll();

    sendWord({8'hFF, 24'h0002A5});        // Lone high half, dropped
    sendWord(regWord(nopReg, 16'hBEEF));  // Filler
    repeat (4) begin
      r = $random(seed);
      lowBits = {1'b1, r[22:0]};  // Bit 23 set marks a low half
      sendWord({8'hFF, 1'b1, ~lowBits[22:0]});  // Replaced by the next low half
      sendWord({8'hFF, lowBits});
      r = $random(seed);
      highBits = r[9:0];
      sendWord({8'hFF, 14'b0, highBits});
      expQ.push_back({upBdHigh, 20'b0, highBits});
      expQ.push_back({upBdLow, 6'b0, lowBits});
    end
    drainAll();
    expectEmpty();

    sendWord(chanWord(5'd7, 16'h1111));
    chanModel[7] = 16'h1111;
    for (int i = 0; i < 6; i++) begin
      r = $random(seed);
      sendWord(chanWord(r[20:16], r[15:0]));
      chanModel[r[20:16]] = r[15:0];
    end
    sendWord(chanWord(5'd7, 16'hA5C3));  // Last write wins
    chanModel[7] = 16'hA5C3;
    for (int id = 0; id < 32; id += 5) begin
      sendWord(regWord(readbackReg, 16'(id)));
      expQ.push_back({upReadback, 9'b0, 5'(id), chanModel[id]});
    end
    sendWord(regWord(readbackReg, 16'd7));
    expQ.push_back({upReadback, 9'b0, 5'd7, chanModel[7]});
    drainAll();
    expectEmpty();

    repeat (3) begin  // Each value differs from the last
      r = $random(seed);
      data = r[15:0];
      data[3:0] = ~ledModel;
      sendWord(regWord(ledReg, data));
      ledModel = data[3:0];
      waitLed(ledModel);
    end
    // Other registers carry a nibble that would change led
    sendWord(regWord(5'd5, {12'hFFF, ~ledModel}));
    sendWord(regWord(nopReg, {12'hFFF, ~ledModel}));
    expectEmpty();
    checkValue("led", 32'(ledModel), 32'(led));

    for (int i = 0; i < FifoDepth + 4; i++) begin  // Tail dropped without reads
      r = $random(seed);
      w = toBdWord(r[25:20], r[19:0]);
      sendWord(w);
      if (i < FifoDepth) begin
        expQ.push_back(w);
      end
    end
    waitOverflow();
    drainAll();
    expectEmpty();

    @(posedge okClk);
    arstN <= 1'b0;
    repeat (2) @(posedge okClk);
    arstN <= 1'b1;
    checkReset();

    $display("Totals: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
source/coreHarnessPkg.sv
source/downstreamDecoder.sv
source/configRegisters.sv
source/upstreamEncoder.sv
source/upstreamFifo.sv
source/coreHarness.sv
tb/coreHarness_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the core harness testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f verilog.f --top-module coreHarness_tb -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/simv)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" <<< "$output"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
